/* hw/credit_pkg.sv */
`default_nettype none

// --------------------
// Credit accounting definitions shared by the sender and the receiver.
// --------------------

package credit_pkg;

  // Width of every credit quantity on the link.
  // Five bits hold any credit count up to the limit below.
  localparam int credit_width = 5;

  // Unsigned credit count.
  // It is used for the initial credit, the withhold value and the counter state.
  typedef logic [credit_width-1:0] credit_t;

  // Largest credit capacity that a credit_t can represent.
  // The max_credit parameter must not exceed it.
  localparam int max_credit_limit = 31;

endpackage

`default_nettype wire

/* hw/link_pkg.sv */
`default_nettype none

// --------------------
// Flit format and channel limits of the link.
// --------------------

package link_pkg;

  // Payload width of one flit in bits.
  localparam int flit_width = 32;

  // One flit as it travels from the source to the sink.
  // There is no header or sideband, just the payload word.
  typedef logic [flit_width-1:0] flit_t;

  // Largest number of register stages in each direction of the channel.
  // Deeper channels need more credit to keep the link busy.
  localparam int max_link_stages = 8;

endpackage

`default_nettype wire

/* hw/credit_link_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One hop of the credit link.
// The flit travels forward with valid and data, one strobe per flit.
// The credit travels backward as a one-cycle strobe per returned credit.
// All four signals belong to the clk domain.
interface credit_link_if;
  import link_pkg::*;

  // Forward flit strobe without back-pressure.
  logic  valid;
  // Flit payload that is meaningful only while valid is high.
  flit_t data;
  // Backward credit strobe.
  logic  credit;
  // High while the sending side is in reset.
  logic  credit_stall;

  // The flit source drives the forward signals and listens for credits.
  modport tx (
    output valid,
    output data,
    output credit_stall,
    input  credit
  );

  // The flit sink takes the forward signals and returns credits.
  modport rx (
    input  valid,
    input  data,
    input  credit_stall,
    output credit
  );

endinterface

`default_nettype wire

/* hw/credit_counter.sv */
`timescale 1ns/1ps
`default_nettype none

// Saturating credit counter for the sender side.
// The count is loaded from initial_value while rst_n is low.
// A returning credit can be spent in the same cycle it arrives.
module credit_counter #(
  parameter int max_value = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                incr_valid,
  input  logic                decr_valid,
  output logic                decr_ready,
  input  credit_pkg::credit_t initial_value,
  input  credit_pkg::credit_t withhold,
  output credit_pkg::credit_t value,
  output credit_pkg::credit_t available
);
  import credit_pkg::*;

  // The count never goes past the capacity, and never past what credit_t holds.
  localparam int cap_int = (max_value > max_credit_limit) ? max_credit_limit : max_value;
  localparam credit_t cap = credit_t'(cap_int);

  // One spare bit so that a full count plus an incoming credit does not wrap.
  typedef logic [credit_width:0] wide_t;

  wide_t total;
  wide_t spendable;
  wide_t next_wide;
  logic  decr;

  // --------------------
  // Available credit
  // --------------------

  // The incoming credit is counted before the withhold is taken off.
  // A withhold larger than the total leaves nothing to spend.
  always_comb begin
    total = {1'b0, value} + wide_t'(incr_valid);
    if (total > {1'b0, withhold}) begin
      spendable = total - {1'b0, withhold};
    end else begin
      spendable = '0;
    end
  end

  // Clamp to the capacity so the output always fits a credit_t.
  assign available = (spendable > {1'b0, cap}) ? cap : spendable[credit_width-1:0];

  // A flit may leave only while some credit is free.
  assign decr_ready = (available != '0);
  assign decr = decr_valid && decr_ready;

  // --------------------
  // Count update
  // --------------------

  // An increment and a decrement together cancel out.
  // Withheld credits stay in the count, they are only kept from being spent.
  always_comb begin
    next_wide = total - wide_t'(decr);
    if (next_wide > {1'b0, cap}) begin
      next_wide = {1'b0, cap};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value <= initial_value;
    end else begin
      value <= next_wide[credit_width-1:0];
    end
  end

endmodule

`default_nettype wire

/* hw/credit_sender.sv */
`timescale 1ns/1ps
`default_nettype none

// Sender side of the credit link.
// It turns the ready/valid push side into a valid strobe on the link.
// Each accepted flit spends one credit, each credit strobe returns one.
module credit_sender #(
  parameter int max_credit      = 8,
  parameter bit reg_pop_outputs = 1'b1
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push_valid,
  output logic                push_ready,
  input  link_pkg::flit_t     push_data,
  credit_link_if.tx           link,
  input  credit_pkg::credit_t credit_initial,
  input  credit_pkg::credit_t credit_withhold,
  output credit_pkg::credit_t credit_count,
  output credit_pkg::credit_t credit_available
);

  logic counter_ready;
  logic stall_q;
  logic push_fire;

  // --------------------
  // Reset stall
  // --------------------

  // The stall is set in reset and clears on the first edge after rst_n rises.
  // While it is high the far side must not return credits, since the counter
  // is still being loaded and would drop them.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stall_q <= 1'b1;
    end else begin
      stall_q <= 1'b0;
    end
  end

  assign link.credit_stall = stall_q;

  // --------------------
  // Credit accounting
  // --------------------

  // Requests are held off while stalled, so push_ready is low throughout reset.
  credit_counter #(
    .max_value (max_credit)
  ) i_counter (
    .clk           (clk),
    .rst_n         (rst_n),
    .incr_valid    (link.credit),
    .decr_valid    (push_valid && !stall_q),
    .decr_ready    (counter_ready),
    .initial_value (credit_initial),
    .withhold      (credit_withhold),
    .value         (credit_count),
    .available     (credit_available)
  );

  assign push_ready = counter_ready && !stall_q;
  assign push_fire = push_valid && push_ready;

  // --------------------
  // Flit output
  // --------------------

  if (reg_pop_outputs) begin : gen_reg_out
    // One cycle of retiming on the link side.
    // Data only loads on a transfer, the valid bit carries the control state.
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        link.valid <= 1'b0;
      end else begin
        link.valid <= push_fire;
      end
    end

    always_ff @(posedge clk) begin
      if (push_fire) begin
        link.data <= push_data;
      end
    end
  end else begin : gen_pass_out
    // Cut-through: the flit is on the link in the cycle it is accepted.
    assign link.valid = push_fire;
    assign link.data  = push_data;
  end

endmodule

`default_nettype wire

/* hw/link_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

// Pipelined channel between the sender and the receiver.
// Flits and the stall flag move forward, credits move backward,
// each through the same number of register stages.
module link_pipe #(
  parameter int link_stages = 2
) (
  input  logic      clk,
  input  logic      rst_n,
  credit_link_if.rx near,
  credit_link_if.tx far
);
  import link_pkg::*;

  // Depths beyond the channel limit are cut back to it.
  localparam int stages = (link_stages > max_link_stages) ? max_link_stages : link_stages;

  if (stages == 0) begin : gen_wires
    // No stages, so both directions are plain connections.
    assign far.valid        = near.valid;
    assign far.data         = near.data;
    assign far.credit_stall = near.credit_stall;
    assign near.credit      = far.credit;
  end else begin : gen_stages
    logic [stages-1:0] valid_q;
    logic [stages-1:0] stall_q;
    logic [stages-1:0] credit_q;
    flit_t             data_q [stages];

    // --------------------
    // Control chains
    // --------------------

    // Stage 0 sits next to the input of each chain.
    // The stall chain resets high so the receiver sees a stall until the
    // sender's own stall has travelled all the way through.
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_q  <= '0;
        stall_q  <= '1;
        credit_q <= '0;
      end else begin
        valid_q[0]  <= near.valid;
        stall_q[0]  <= near.credit_stall;
        credit_q[0] <= far.credit;
        for (int i = 1; i < stages; i++) begin
          valid_q[i]  <= valid_q[i-1];
          stall_q[i]  <= stall_q[i-1];
          credit_q[i] <= credit_q[i-1];
        end
      end
    end

    // --------------------
    // Data chain
    // --------------------

    // Each data stage loads only when the valid bit beside it moves in.
    always_ff @(posedge clk) begin
      if (near.valid) begin
        data_q[0] <= near.data;
      end
      for (int i = 1; i < stages; i++) begin
        if (valid_q[i-1]) begin
          data_q[i] <= data_q[i-1];
        end
      end
    end

    assign far.valid        = valid_q[stages-1];
    assign far.data         = data_q[stages-1];
    assign far.credit_stall = stall_q[stages-1];
    assign near.credit      = credit_q[stages-1];
  end

endmodule

`default_nettype wire

/* hw/credit_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

// Receiver side of the credit link.
// Every arriving flit is written into a FIFO with one entry per credit.
// The sender never has more flits in flight than credits, so the FIFO
// cannot overflow and the link needs no back-pressure.
module credit_receiver #(
  parameter int max_credit = 8
) (
  input  logic            clk,
  input  logic            rst_n,
  credit_link_if.rx       link,
  output logic            pop_valid,
  input  logic            pop_ready,
  output link_pkg::flit_t pop_data
);
  import link_pkg::*;
  import credit_pkg::*;

  // The FIFO depth matches the credit capacity.
  localparam int depth = (max_credit > max_credit_limit) ? max_credit_limit : max_credit;
  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;

  typedef logic [ptr_width-1:0] ptr_t;

  localparam ptr_t last_ptr = ptr_t'(depth - 1);

  flit_t   mem [depth];
  ptr_t    wr_ptr;
  ptr_t    rd_ptr;
  credit_t occupancy;
  logic    pop_fire;
  logic    credit_q;

  // Pointers wrap at the depth, which need not be a power of two.
  function automatic ptr_t next_ptr(input ptr_t ptr);
    if (ptr == last_ptr) begin
      return '0;
    end
    return ptr + ptr_t'(1);
  endfunction

  // --------------------
  // Storage
  // --------------------

  // Every valid flit is written, there is no full check on this side.
  always_ff @(posedge clk) begin
    if (link.valid) begin
      mem[wr_ptr] <= link.data;
    end
  end

  // The head entry is presented to the sink directly from the array.
  assign pop_data  = mem[rd_ptr];
  assign pop_valid = (occupancy != '0);
  assign pop_fire  = pop_valid && pop_ready;

  // --------------------
  // Pointers and count
  // --------------------

  // A flit written in one cycle is counted at the edge, so it shows on
  // pop_valid from the next cycle on.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
    end else begin
      if (link.valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_fire) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({link.valid, pop_fire})
        2'b10:   occupancy <= occupancy + credit_t'(1);
        2'b01:   occupancy <= occupancy - credit_t'(1);
        default: occupancy <= occupancy;
      endcase
    end
  end

  // --------------------
  // Credit return
  // --------------------

  // One credit goes back in the cycle after each pop.
  // While the sender is stalled the FIFO is empty, so nothing is dropped here.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= pop_fire && !link.credit_stall;
    end
  end

  assign link.credit = credit_q;

endmodule

`default_nettype wire

/* hw/credit_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Top level of the credit link.
// Flits go from the ready/valid source through the sender, the channel
// and the receiver FIFO to the ready/valid sink.
// The credit counter state is brought out for monitoring.
module credit_link_top #(
  parameter int max_credit      = 8,
  parameter int link_stages     = 2,
  parameter bit reg_pop_outputs = 1'b1
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  output logic                in_ready,
  input  link_pkg::flit_t     in_data,
  output logic                out_valid,
  input  logic                out_ready,
  output link_pkg::flit_t     out_data,
  input  credit_pkg::credit_t credit_initial,
  input  credit_pkg::credit_t credit_withhold,
  output credit_pkg::credit_t credit_count,
  output credit_pkg::credit_t credit_available
);

  // Sender to channel, and channel to receiver.
  credit_link_if link_near ();
  credit_link_if link_far ();

  credit_sender #(
    .max_credit      (max_credit),
    .reg_pop_outputs (reg_pop_outputs)
  ) i_sender (
    .clk              (clk),
    .rst_n            (rst_n),
    .push_valid       (in_valid),
    .push_ready       (in_ready),
    .push_data        (in_data),
    .link             (link_near.tx),
    .credit_initial   (credit_initial),
    .credit_withhold  (credit_withhold),
    .credit_count     (credit_count),
    .credit_available (credit_available)
  );

  // Same depth in both directions, so the round trip is symmetric.
  link_pipe #(
    .link_stages (link_stages)
  ) i_pipe (
    .clk   (clk),
    .rst_n (rst_n),
    .near  (link_near.rx),
    .far   (link_far.tx)
  );

  credit_receiver #(
    .max_credit (max_credit)
  ) i_receiver (
    .clk       (clk),
    .rst_n     (rst_n),
    .link      (link_far.rx),
    .pop_valid (out_valid),
    .pop_ready (out_ready),
    .pop_data  (out_data)
  );

endmodule

`default_nettype wire

/* test/credit_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// Self-checking testbench for the credit link.
// Each pattern line is one test: reset, an optional phase with all credit
// withheld, a window with the sink held off, then traffic until drained.
module credit_link_tb;
  import credit_pkg::*;
  import link_pkg::*;

  localparam int max_tests       = 64;
  localparam int reset_cycles    = 8;
  localparam int idle_cycles     = 20;
  localparam int withhold_cycles = 16;

  logic    clk;
  logic    rst_n;
  logic    in_valid;
  logic    in_ready;
  flit_t   in_data;
  logic    out_valid;
  logic    out_ready;
  flit_t   out_data;
  credit_t credit_initial;
  credit_t credit_withhold;
  credit_t credit_count;
  credit_t credit_available;

  // The test table is filled from the pattern file.
  logic [8*24-1:0] test_name [max_tests];
  int test_initial [max_tests];
  int test_withhold [max_tests];
  int test_flits [max_tests];
  int test_ready [max_tests];
  int test_stall [max_tests];
  int num_tests;
  int limit_cycles;
  bit tests_loaded = 1'b0;

  // Run state shared by the tasks below.
  flit_t           scoreboard [$];
  logic [31:0]     rand_state;
  logic [8*24-1:0] cur_name;
  int              errors;
  int              total_flits;
  int              sent;
  int              received;
  int              flits_goal;
  bit              send_enable;
  bit              fired_in;
  logic            seen_in_ready;
  credit_t         seen_available;

  credit_link_top i_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .in_valid         (in_valid),
    .in_ready         (in_ready),
    .in_data          (in_data),
    .out_valid        (out_valid),
    .out_ready        (out_ready),
    .out_data         (out_data),
    .credit_initial   (credit_initial),
    .credit_withhold  (credit_withhold),
    .credit_count     (credit_count),
    .credit_available (credit_available)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // 32-bit xorshift generator for flit payloads.
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // The sink is held off during the stall window, then follows the pattern.
  function automatic bit ready_for(input int c, input int pattern, input int stall);
    if (c < stall) begin
      return 1'b0;
    end
    return pattern[(c - stall) % 8];
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("mismatch test %0s %s expected 0x%0h actual 0x%0h", cur_name, what,
             expected, actual);
    errors++;
  endtask

  task automatic load_patterns();
    int              fd;
    int              n;
    logic [8*128-1:0] line_buf;
    logic [8*24-1:0] name_buf;
    int              v_init;
    int              v_withhold;
    int              v_flits;
    int              v_ready;
    int              v_stall;
    num_tests    = 0;
    limit_cycles = 0;
    fd = $fopen("test/credit_link_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open the pattern file test/credit_link_patterns.txt");
    end else begin
      while (!$feof(fd) && num_tests < max_tests) begin
        line_buf = '0;
        n = $fgets(line_buf, fd);
        if (n > 0) begin
          // Comment lines stop after the first token and are skipped.
          n = $sscanf(line_buf, "%s %d %d %d %h %d", name_buf, v_init, v_withhold,
                      v_flits, v_ready, v_stall);
          if (n == 6) begin
            test_name[num_tests]     = name_buf;
            test_initial[num_tests]  = v_init;
            test_withhold[num_tests] = v_withhold;
            test_flits[num_tests]    = v_flits;
            test_ready[num_tests]    = v_ready;
            test_stall[num_tests]    = v_stall;
            limit_cycles += v_flits * 64 + 200;
            num_tests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // A flit stays offered, data held, until it is taken.
  task automatic offer_flit();
    if (!in_valid && send_enable && sent < flits_goal) begin
      rand_state = xorshift32(rand_state);
      in_data    = rand_state;
      in_valid   = 1'b1;
    end
  endtask

  // --------------------
  // One clock cycle
  // --------------------

  // Outputs are sampled at the edge, inputs change 0.5 ns later.
  task automatic step_cycle(input bit ready_next);
    flit_t expected;
    @(posedge clk);
    fired_in       = in_valid && in_ready;
    seen_in_ready  = in_ready;
    seen_available = credit_available;
    if (fired_in) begin
      scoreboard.push_back(in_data);
      sent++;
    end
    if (out_valid && out_ready) begin
      received++;
      if (scoreboard.size() == 0) begin
        $display("test %0s: flit 0x%h left the link with none outstanding", cur_name,
                 out_data);
        errors++;
      end else begin
        expected = scoreboard.pop_front();
        if (out_data !== expected) begin
          report_mismatch("out_data", expected, out_data);
        end
      end
    end
    #0.5;
    if (fired_in) begin
      in_valid = 1'b0;
    end
    offer_flit();
    out_ready = ready_next;
  endtask

  task automatic apply_reset(input int init, input int withhold);
    int expected_available;
    expected_available = (init > withhold) ? init - withhold : 0;
    rst_n           = 1'b0;
    in_valid        = 1'b0;
    out_ready       = 1'b0;
    credit_initial  = credit_t'(init);
    credit_withhold = credit_t'(withhold);
    for (int i = 0; i < reset_cycles; i++) begin
      @(posedge clk);
      // The first edge loads the reset state, so checking starts after it.
      if (i > 0 && (in_ready !== 1'b0 || out_valid !== 1'b0)) begin
        $display("test %0s: in_ready or out_valid not low during reset", cur_name);
        errors++;
      end
      #0.5;
    end
    rst_n = 1'b1;
    if (credit_count !== credit_t'(init)) begin
      report_mismatch("credit_count after reset", init, credit_count);
    end
    if (credit_available !== credit_t'(expected_available)) begin
      report_mismatch("credit_available after reset", expected_available, credit_available);
    end
  endtask

  // --------------------
  // One test
  // --------------------

  task automatic run_test(input int t);
    int c;
    int avail_start;
    int stall_accepts;
    int expected_accepts;
    cur_name    = test_name[t];
    flits_goal  = test_flits[t];
    sent        = 0;
    received    = 0;
    send_enable = 1'b0;
    scoreboard.delete();
    apply_reset(test_initial[t], test_withhold[t]);
    send_enable = 1'b1;

    // With every credit withheld the source must stay blocked.
    if (test_withhold[t] >= test_initial[t]) begin
      offer_flit();
      repeat (withhold_cycles) begin
        step_cycle(1'b0);
        if (seen_in_ready !== 1'b0) begin
          $display("test %0s: in_ready rose while all credit was withheld", cur_name);
          errors++;
        end
      end
      if (sent != 0) begin
        $display("test %0s: %0d flits accepted with all credit withheld", cur_name, sent);
        errors++;
      end
      credit_withhold = '0;
    end

    // The free credit when the stall window opens.
    // Lifting a full withhold frees the whole initial credit.
    if (test_withhold[t] >= test_initial[t]) begin
      avail_start = test_initial[t];
    end else begin
      avail_start = test_initial[t] - test_withhold[t];
    end

    // Traffic runs until every flit has reached the sink.
    offer_flit();
    out_ready     = ready_for(0, test_ready[t], test_stall[t]);
    c             = 0;
    stall_accepts = 0;
    while (received < flits_goal) begin
      step_cycle(ready_for(c + 1, test_ready[t], test_stall[t]));
      if (c == 0 && seen_available !== credit_t'(avail_start)) begin
        report_mismatch("credit_available at stall start", avail_start, seen_available);
      end
      if (c < test_stall[t] && fired_in) begin
        stall_accepts++;
      end
      // Only a window well past the credit count has settled.
      if (c == test_stall[t] - 1 && test_stall[t] >= avail_start + 4) begin
        expected_accepts = (avail_start < flits_goal) ? avail_start : flits_goal;
        if (stall_accepts != expected_accepts) begin
          report_mismatch("flits accepted in stall", expected_accepts, stall_accepts);
        end
        if (expected_accepts == avail_start && seen_in_ready !== 1'b0) begin
          $display("test %0s: in_ready still high after credit ran out", cur_name);
          errors++;
        end
      end
      c++;
    end

    // Idle cycles let the last credits travel home.
    repeat (idle_cycles) begin
      step_cycle(1'b1);
    end
    if (scoreboard.size() != 0 || sent != flits_goal) begin
      $display("test %0s: %0d flits sent, %0d still outstanding", cur_name, sent,
               scoreboard.size());
      errors++;
    end
    if (credit_count !== credit_t'(test_initial[t])) begin
      report_mismatch("credit_count after drain", test_initial[t], credit_count);
    end
    total_flits += received;
  endtask

  initial begin
    rst_n           = 1'b0;
    in_valid        = 1'b0;
    in_data         = '0;
    out_ready       = 1'b0;
    credit_initial  = '0;
    credit_withhold = '0;
    errors          = 0;
    total_flits     = 0;
    sent            = 0;
    received        = 0;
    flits_goal      = 0;
    send_enable     = 1'b0;
    rand_state      = 32'd64832;
    load_patterns();
    if (num_tests == 0) begin
      $display("the pattern file gave no tests to run");
      errors++;
    end else begin
      tests_loaded = 1'b1;
      for (int t = 0; t < num_tests; t++) begin
        run_test(t);
      end
    end
    $display("%0d tests, %0d flits, %0d errors", num_tests, total_flits, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // The watchdog is sized from the flit counts of all tests.
  initial begin
    wait (tests_loaded);
    repeat (limit_cycles) @(posedge clk);
    $display("run timed out after %0d cycles", limit_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* credit_link_top.f */
hw/credit_pkg.sv
hw/link_pkg.sv
hw/credit_link_if.sv
hw/credit_counter.sv
hw/credit_sender.sv
hw/link_pipe.sv
hw/credit_receiver.sv
hw/credit_link_top.sv
test/credit_link_tb.sv

/* test/credit_link_patterns.txt */
# name  credit_initial  credit_withhold  flits  out_ready_pattern(hex)  stall_cycles
# Bit n of the ready pattern drives out_ready n cycles after the stall window, repeating every 8.
full_credit_stream 8 0 32 ff 0
single_credit 1 0 12 ff 0
two_credits 2 0 12 ff 0
three_credits 3 0 16 ff 0
five_credits 5 0 16 ff 0
alternate_ready 8 0 24 55 0
alternate_ready_inv 8 0 24 aa 0
quarter_ready 8 0 16 11 0
sparse_ready 8 0 12 01 0
burst_ready 8 0 24 0f 0
mostly_ready 8 0 24 7f 0
single_credit_sparse 1 0 8 81 0
stall_full_credit 8 0 24 ff 20
stall_one_credit 1 0 8 ff 12
stall_three_credits 3 0 12 ff 16
stall_few_flits 8 0 5 ff 20
stall_exact_flits 8 0 8 ff 20
stall_then_bursty 8 0 20 3c 24
withhold_one 8 1 20 ff 20
withhold_half 8 4 20 ff 16
withhold_partial_slow 5 2 14 55 12
withhold_all 4 4 12 ff 20
withhold_all_one 1 1 6 ff 12
withhold_all_full 8 8 16 ff 24
withhold_above 2 6 10 ff 0
withhold_max_word 3 31 10 ff 16
withhold_all_bursty 6 6 18 c3 20
long_mixed_traffic 8 2 48 b6 28
